// File: include/accel_regs.svh
`ifndef ACCEL_REGS_SVH
`define ACCEL_REGS_SVH

// Decoded low bits of the APB address
`define REG_OFFSET_W 8

// Byte offsets
`define REG_X_ADDR 8'h00
`define REG_W_ADDR 8'h04
`define REG_Z_ADDR 8'h08
`define REG_LEN    8'h0C
`define REG_CTRL   8'h10
`define REG_STATUS 8'h14

// Bit positions
`define CTRL_START_BIT  0
`define STATUS_BUSY_BIT 0
`define STATUS_DONE_BIT 1

`endif

// File: logic/accel_ctrl_regs.sv
`timescale 1ns/1ps
`include "accel_regs.svh"

module accel_ctrl_regs
  import accel_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  apb_psel_i,
  input  logic  apb_penable_i,
  input  logic  apb_pwrite_i,
  input  addr_t apb_paddr_i,
  input  data_t apb_pwdata_i,
  output data_t apb_prdata_o,
  output logic  apb_pready_o,
  output logic  apb_pslverr_o,
  output logic  start_o,
  output addr_t x_addr_o,
  output addr_t w_addr_o,
  output addr_t z_addr_o,
  output len_t  len_o,
  input  logic  done_i,
  output logic  irq_o
);

  logic [`REG_OFFSET_W-1:0] offset;
  logic  access;
  logic  known;
  logic  job_reg;
  logic  wr_ok;
  logic  go;
  addr_t x_addr_q;
  addr_t w_addr_q;
  addr_t z_addr_q;
  len_t  len_q;
  logic  start_q;
  logic  busy_q;
  logic  done_q;

  assign access = apb_psel_i & apb_penable_i;
  assign offset = apb_paddr_i[`REG_OFFSET_W-1:0];

  always_comb begin
    known   = 1'b1;
    job_reg = 1'b0;
    case (offset)
      `REG_X_ADDR, `REG_W_ADDR, `REG_Z_ADDR, `REG_LEN, `REG_CTRL: job_reg = 1'b1;
      `REG_STATUS: job_reg = 1'b0;
      default: known = 1'b0;
    endcase
  end

  // Zero wait states
  assign apb_pready_o  = access;
  assign apb_pslverr_o = access & (~known | (apb_pwrite_i & busy_q & job_reg));

  assign wr_ok = access & apb_pwrite_i & ~apb_pslverr_o;
  assign go    = wr_ok & (offset == `REG_CTRL) & apb_pwdata_i[`CTRL_START_BIT];

  always_comb begin
    apb_prdata_o = '0;
    case (offset)
      `REG_X_ADDR: apb_prdata_o = x_addr_q;
      `REG_W_ADDR: apb_prdata_o = w_addr_q;
      `REG_Z_ADDR: apb_prdata_o = z_addr_q;
      `REG_LEN:    apb_prdata_o = data_t'(len_q);
      `REG_STATUS: begin
        apb_prdata_o[`STATUS_BUSY_BIT] = busy_q;
        apb_prdata_o[`STATUS_DONE_BIT] = done_q;
      end
      default: apb_prdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      x_addr_q <= '0;
      w_addr_q <= '0;
      z_addr_q <= '0;
      len_q    <= '0;
      start_q  <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      start_q <= go;
      if (wr_ok && offset == `REG_X_ADDR) x_addr_q <= apb_pwdata_i;
      if (wr_ok && offset == `REG_W_ADDR) w_addr_q <= apb_pwdata_i;
      if (wr_ok && offset == `REG_Z_ADDR) z_addr_q <= apb_pwdata_i;
      if (wr_ok && offset == `REG_LEN) len_q <= apb_pwdata_i[LEN_W-1:0];
      // Busy rises with the start pulse
      if (go) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else if (wr_ok && offset == `REG_STATUS && apb_pwdata_i[`STATUS_DONE_BIT]) begin
        done_q <= 1'b0;
      end
    end
  end

  assign start_o  = start_q;
  assign x_addr_o = x_addr_q;
  assign w_addr_o = w_addr_q;
  assign z_addr_o = z_addr_q;
  assign len_o    = len_q;
  assign irq_o    = done_q;

endmodule : accel_ctrl_regs

// File: logic/accel_mac.sv
`timescale 1ns/1ps

module accel_mac
  import accel_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  len_t  len_i,
  input  logic  opnd_valid_i,
  input  data_t opnd_data_i,
  output acc_t  acc_o,
  output logic  acc_valid_o
);

  operand_t x_q;
  operand_t w_op;
  acc_t     product;
  len_t     pairs_q;
  len_t     pairs_nxt;
  logic     sel_w_q;
  acc_t     acc_q;
  logic     valid_q;

  assign w_op      = operand_t'(opnd_data_i[OPND_W-1:0]);
  assign product   = acc_t'(x_q) * acc_t'(w_op);
  assign pairs_nxt = pairs_q + len_t'(1);

  // X operand waits here for its W partner
  always_ff @(posedge clk_i) begin
    if (opnd_valid_i && !sel_w_q) x_q <= operand_t'(opnd_data_i[OPND_W-1:0]);
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      pairs_q <= '0;
      sel_w_q <= 1'b0;
      valid_q <= 1'b0;
    end else if (clear_i) begin
      acc_q   <= '0;
      pairs_q <= '0;
      sel_w_q <= 1'b0;
      valid_q <= (len_i == '0);
    end else if (opnd_valid_i) begin
      sel_w_q <= ~sel_w_q;
      if (sel_w_q) begin
        // Wraps on overflow
        acc_q   <= acc_q + product;
        pairs_q <= pairs_nxt;
        if (pairs_nxt == len_i) valid_q <= 1'b1;
      end
    end
  end

  assign acc_o       = acc_q;
  assign acc_valid_o = valid_q;

endmodule : accel_mac

// File: logic/accel_pkg.sv
package accel_pkg;

  // Memory port word width
  localparam int unsigned DATA_W = 32;

  // Word address width of the job registers
  localparam int unsigned ADDR_W = 32;

  // Signed elements sit in the low half of a word
  localparam int unsigned OPND_W = 16;

  // Accumulator wraps at this width
  localparam int unsigned ACC_W = 32;

  // Element count width
  localparam int unsigned LEN_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [DATA_W-1:0] data_t;

  typedef logic signed [OPND_W-1:0] operand_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  typedef logic [LEN_W-1:0] len_t;

  // Streamer FSM
  typedef enum logic [2:0] {
    IDLE,
    READ,
    DRAIN,
    WRITE,
    WAIT_WGNT
  } stream_state_e;

endpackage : accel_pkg

// File: logic/accel_streamer.sv
`timescale 1ns/1ps

module accel_streamer
  import accel_pkg::*;
#(
  parameter int unsigned MaxOutstanding = 4
)(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          start_i,
  input  addr_t         x_addr_i,
  input  addr_t         w_addr_i,
  input  addr_t         z_addr_i,
  input  len_t          len_i,
  output logic          done_o,
  tcdm_if.master        tcdm,
  output logic          opnd_valid_o,
  output data_t         opnd_data_o,
  output logic          clear_o,
  input  acc_t          acc_i,
  input  logic          acc_valid_i
);

  localparam int unsigned CntW = $clog2(MaxOutstanding + 1);

  stream_state_e state_q;

  logic            req_q;
  logic            wen_q;
  addr_t           add_q;
  data_t           data_q;
  addr_t           x_ptr_q;
  addr_t           w_ptr_q;
  len_t            pairs_left_q;
  logic            sel_w_q;
  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic            wr_pend_q;
  logic            done_q;
  logic            accept;
  logic            rd_return;
  logic            issue;
  logic            wr_ready;

  assign accept    = req_q & tcdm.gnt;
  // The first response after the Z write belongs to it
  assign rd_return = tcdm.r_valid & ~wr_pend_q;
  assign issue     = (state_q == READ) && (!req_q || accept) && (pairs_left_q != '0)
                     && (cnt_q < CntW'(MaxOutstanding));
  assign wr_ready  = (cnt_q == '0) & acc_valid_i;

  // Reads raised but not yet returned
  always_comb begin
    cnt_d = cnt_q;
    if (issue) cnt_d = cnt_d + 1'b1;
    if (rd_return) cnt_d = cnt_d - 1'b1;
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      req_q        <= 1'b0;
      wen_q        <= 1'b1;
      pairs_left_q <= '0;
      sel_w_q      <= 1'b0;
      cnt_q        <= '0;
      wr_pend_q    <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      cnt_q  <= cnt_d;
      done_q <= 1'b0;
      if (tcdm.r_valid) wr_pend_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            pairs_left_q <= len_i;
            sel_w_q      <= 1'b0;
            state_q      <= (len_i == '0) ? DRAIN : READ;
          end
        end
        READ: begin
          if (issue) begin
            req_q   <= 1'b1;
            wen_q   <= 1'b1;
            sel_w_q <= ~sel_w_q;
            if (sel_w_q) pairs_left_q <= pairs_left_q - len_t'(1);
          end else if (accept) begin
            req_q <= 1'b0;
          end
          if (pairs_left_q == '0 && (!req_q || accept)) state_q <= DRAIN;
        end
        DRAIN: begin
          if (wr_ready) begin
            req_q   <= 1'b1;
            wen_q   <= 1'b0;
            state_q <= WRITE;
          end
        end
        WRITE, WAIT_WGNT: begin
          if (accept) begin
            req_q     <= 1'b0;
            wen_q     <= 1'b1;
            done_q    <= 1'b1;
            wr_pend_q <= 1'b1;
            state_q   <= IDLE;
          end else begin
            state_q <= WAIT_WGNT;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address and data payload, held while the request waits
  always_ff @(posedge clk_i) begin
    if (start_i && state_q == IDLE) begin
      x_ptr_q <= x_addr_i;
      w_ptr_q <= w_addr_i;
    end else if (issue) begin
      if (sel_w_q) begin
        add_q   <= w_ptr_q;
        w_ptr_q <= w_ptr_q + addr_t'(1);
      end else begin
        add_q   <= x_ptr_q;
        x_ptr_q <= x_ptr_q + addr_t'(1);
      end
    end else if (state_q == DRAIN && wr_ready) begin
      add_q  <= z_addr_i;
      data_q <= data_t'(acc_i);
    end
  end

  assign tcdm.req  = req_q;
  assign tcdm.wen  = wen_q;
  assign tcdm.add  = add_q;
  assign tcdm.data = data_q;

  assign opnd_valid_o = rd_return;
  assign opnd_data_o  = tcdm.r_data;
  assign clear_o      = start_i & (state_q == IDLE);
  assign done_o       = done_q;

endmodule : accel_streamer

// File: logic/accel_wrap.sv
`timescale 1ns/1ps

module accel_wrap
  import accel_pkg::*;
#(
  parameter int unsigned AddrWidth      = 32,
  parameter int unsigned MaxOutstanding = 4
)(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  apb_psel_i,
  input  logic  apb_penable_i,
  input  logic  apb_pwrite_i,
  input  addr_t apb_paddr_i,
  input  data_t apb_pwdata_i,
  output data_t apb_prdata_o,
  output logic  apb_pready_o,
  output logic  apb_pslverr_o,
  output logic  mem_req_o,
  output logic  mem_wen_o,
  output addr_t mem_add_o,
  output data_t mem_data_o,
  input  logic  mem_gnt_i,
  input  logic  mem_r_valid_i,
  input  data_t mem_r_data_i,
  output logic  irq_o
);

  logic  start;
  addr_t x_addr;
  addr_t w_addr;
  addr_t z_addr;
  len_t  len;
  logic  done;
  logic  irq;
  logic  opnd_valid;
  data_t opnd_data;
  logic  clear;
  acc_t  acc;
  logic  acc_valid;
  logic  accept_in;
  logic  accept_out;
  logic  wr_hold;

  tcdm_if #(.AddrWidth(AddrWidth)) tcdm ();

  assign accept_in  = tcdm.req & tcdm.gnt;
  assign accept_out = mem_req_o & mem_gnt_i;
  // Interrupt must not overtake the Z write still held at the boundary
  assign wr_hold    = mem_req_o & ~mem_wen_o & ~mem_gnt_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      // Inputs
      tcdm.gnt     <= 1'b0;
      tcdm.r_valid <= 1'b0;
      tcdm.r_data  <= '0;
      // Outputs
      mem_req_o  <= 1'b0;
      mem_wen_o  <= 1'b1;
      mem_add_o  <= '0;
      mem_data_o <= '0;
      irq_o      <= 1'b0;
    end else begin
      // Grant only when the request stage is free next cycle
      tcdm.gnt     <= ~accept_in & (~mem_req_o | accept_out);
      tcdm.r_valid <= mem_r_valid_i;
      tcdm.r_data  <= mem_r_data_i;
      if (accept_in) begin
        mem_req_o  <= 1'b1;
        mem_wen_o  <= tcdm.wen;
        mem_add_o  <= tcdm.add;
        mem_data_o <= tcdm.data;
      end else if (accept_out) begin
        mem_req_o <= 1'b0;
      end
      irq_o <= irq & ~wr_hold;
    end
  end

  accel_ctrl_regs i_ctrl_regs (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .apb_psel_i    ( apb_psel_i    ),
    .apb_penable_i ( apb_penable_i ),
    .apb_pwrite_i  ( apb_pwrite_i  ),
    .apb_paddr_i   ( apb_paddr_i   ),
    .apb_pwdata_i  ( apb_pwdata_i  ),
    .apb_prdata_o  ( apb_prdata_o  ),
    .apb_pready_o  ( apb_pready_o  ),
    .apb_pslverr_o ( apb_pslverr_o ),
    .start_o       ( start         ),
    .x_addr_o      ( x_addr        ),
    .w_addr_o      ( w_addr        ),
    .z_addr_o      ( z_addr        ),
    .len_o         ( len           ),
    .done_i        ( done          ),
    .irq_o         ( irq           )
  );

  accel_streamer #(
    .MaxOutstanding ( MaxOutstanding )
  ) i_streamer (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .start_i      ( start       ),
    .x_addr_i     ( x_addr      ),
    .w_addr_i     ( w_addr      ),
    .z_addr_i     ( z_addr      ),
    .len_i        ( len         ),
    .done_o       ( done        ),
    .tcdm         ( tcdm.master ),
    .opnd_valid_o ( opnd_valid  ),
    .opnd_data_o  ( opnd_data   ),
    .clear_o      ( clear       ),
    .acc_i        ( acc         ),
    .acc_valid_i  ( acc_valid   )
  );

  accel_mac i_mac (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear      ),
    .len_i        ( len        ),
    .opnd_valid_i ( opnd_valid ),
    .opnd_data_i  ( opnd_data  ),
    .acc_o        ( acc        ),
    .acc_valid_o  ( acc_valid  )
  );

endmodule : accel_wrap

// File: logic/tcdm_if.sv
`timescale 1ns/1ps

interface tcdm_if
  import accel_pkg::*;
#(
  parameter int unsigned AddrWidth = 32
) ();

  // Request channel
  logic                 req;
  logic                 wen;
  logic [AddrWidth-1:0] add;
  data_t                data;

  // Response channel
  logic                 gnt;
  logic                 r_valid;
  data_t                r_data;

  modport master (
    output req, wen, add, data,
    input  gnt, r_valid, r_data
  );

  modport slave (
    input  req, wen, add, data,
    output gnt, r_valid, r_data
  );

endinterface : tcdm_if

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_accel -f vlog.f -o tb_accel || exit 1
./obj_dir/tb_accel > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
exit 0

// File: test/tb_accel.sv
`timescale 1ns/1ps
`include "accel_regs.svh"

module tb_accel
  import accel_pkg::*;
();

  localparam int unsigned MaxOutstanding = 4;
  localparam int unsigned Timeout        = 4000;
  localparam int          HalfPeriod     = 10;
  localparam int          DrvDelay       = 2;
  localparam int          SmpDelay       = 5;

  logic  clk_i;
  logic  rst_ni;
  logic  apb_psel_i;
  logic  apb_penable_i;
  logic  apb_pwrite_i;
  addr_t apb_paddr_i;
  data_t apb_pwdata_i;
  data_t apb_prdata_o;
  logic  apb_pready_o;
  logic  apb_pslverr_o;
  logic  mem_req_o;
  logic  mem_wen_o;
  addr_t mem_add_o;
  data_t mem_data_o;
  logic  mem_gnt_i;
  logic  mem_r_valid_i;
  data_t mem_r_data_i;
  logic  irq_o;
  logic  depth_err;

  string       name_q[$];
  data_t       exp_q[$];
  data_t       act_q[$];
  int unsigned errors;
  int unsigned checks;

  accel_wrap #(.AddrWidth(32), .MaxOutstanding(MaxOutstanding)) dut (.*);

  tb_mem_model #(
    .Depth       ( 1024               ),
    .MaxInFlight ( MaxOutstanding + 2 )
  ) mem_model (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_i       ( mem_req_o     ),
    .wen_i       ( mem_wen_o     ),
    .add_i       ( mem_add_o     ),
    .data_i      ( mem_data_o    ),
    .gnt_o       ( mem_gnt_i     ),
    .r_valid_o   ( mem_r_valid_i ),
    .r_data_o    ( mem_r_data_i  ),
    .depth_err_o ( depth_err     )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #HalfPeriod;
      clk_i = ~clk_i;
    end
  end

  task automatic expect_value(input string name, input data_t exp, input data_t act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  // Compares queued results away from the rising edge
  always @(negedge clk_i) begin
    string name;
    data_t exp;
    data_t act;
    while (act_q.size() > 0) begin
      name = name_q.pop_front();
      exp  = exp_q.pop_front();
      act  = act_q.pop_front();
      checks++;
      if (exp !== act) begin
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        errors++;
      end
    end
  end

  // Signed 16-bit elements, 32-bit wrapping sum
  function automatic acc_t dot_ref(input addr_t x, input addr_t w, input len_t len);
    acc_t  sum;
    data_t xa;
    data_t wa;
    sum = '0;
    for (int unsigned i = 0; i < 32'(len); i++) begin
      xa  = mem_model.mem[x + i];
      wa  = mem_model.mem[w + i];
      sum = sum + operand_t'(xa[15:0]) * operand_t'(wa[15:0]);
    end
    return sum;
  endfunction

  task automatic bus_access(input string name, input logic write, input logic [7:0] offset,
                            input data_t wdata, input logic exp_err, output data_t rdata);
    int unsigned n;
    @(posedge clk_i);
    #DrvDelay;
    apb_psel_i    = 1'b1;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = write;
    apb_paddr_i   = addr_t'(offset);
    apb_pwdata_i  = wdata;
    @(posedge clk_i);
    #DrvDelay;
    apb_penable_i = 1'b1;
    #(SmpDelay - DrvDelay);
    n = 0;
    while (!apb_pready_o && n < Timeout) begin
      @(posedge clk_i);
      #SmpDelay;
      n++;
    end
    if (!apb_pready_o) begin
      $display("%s: APB access at offset %h never got pready", name, offset);
      errors++;
    end
    rdata = apb_prdata_o;
    expect_value({name, " pslverr"}, data_t'(exp_err), data_t'(apb_pslverr_o));
    @(posedge clk_i);
    #DrvDelay;
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
  endtask

  task automatic wait_irq(input string name, input logic level);
    int unsigned n;
    n = 0;
    while (irq_o !== level && n < Timeout) begin
      @(posedge clk_i);
      #SmpDelay;
      n++;
    end
    if (irq_o !== level) begin
      $display("%s: irq_o did not go to %b within %0d cycles", name, level, Timeout);
      errors++;
    end
  endtask

  task automatic start_job(input string name, input addr_t x, input addr_t w, input addr_t z,
                           input len_t len);
    data_t rd;
    for (int unsigned i = 0; i < 32'(len); i++) begin
      mem_model.mem[x + i] = $urandom();
      mem_model.mem[w + i] = $urandom();
    end
    // Stale Z so a missing write is caught
    mem_model.mem[z] = 32'hdead_beef;
    bus_access(name, 1'b1, `REG_X_ADDR, x, 1'b0, rd);
    bus_access(name, 1'b1, `REG_W_ADDR, w, 1'b0, rd);
    bus_access(name, 1'b1, `REG_Z_ADDR, z, 1'b0, rd);
    bus_access(name, 1'b1, `REG_LEN, data_t'(len), 1'b0, rd);
    bus_access(name, 1'b1, `REG_CTRL, data_t'(1) << `CTRL_START_BIT, 1'b0, rd);
  endtask

  task automatic finish_job(input string name, input addr_t x, input addr_t w, input addr_t z,
                            input len_t len);
    data_t rd;
    wait_irq(name, 1'b1);
    expect_value({name, " result"}, data_t'(dot_ref(x, w, len)), mem_model.mem[z]);
    bus_access({name, " status"}, 1'b0, `REG_STATUS, '0, 1'b0, rd);
    expect_value({name, " status"}, data_t'(1) << `STATUS_DONE_BIT, rd);
    // Write 1 to done to drop it and the interrupt
    bus_access({name, " clear"}, 1'b1, `REG_STATUS, data_t'(1) << `STATUS_DONE_BIT, 1'b0, rd);
    wait_irq({name, " clear"}, 1'b0);
    bus_access({name, " cleared"}, 1'b0, `REG_STATUS, '0, 1'b0, rd);
    expect_value({name, " cleared"}, '0, rd);
  endtask

  initial begin
    data_t rd;
    void'($urandom(32'h62ab_595e));
    errors        = 0;
    checks        = 0;
    rst_ni        = 1'b0;
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
    apb_paddr_i   = '0;
    apb_pwdata_i  = '0;
    repeat (5) @(posedge clk_i);
    #DrvDelay;
    rst_ni = 1'b1;

    expect_value("reset irq", '0, data_t'(irq_o));
    bus_access("reset status", 1'b0, `REG_STATUS, '0, 1'b0, rd);
    expect_value("reset status", '0, rd);

    // Job registers
    bus_access("readback x", 1'b1, `REG_X_ADDR, 32'hc0de_1234, 1'b0, rd);
    bus_access("readback x", 1'b0, `REG_X_ADDR, '0, 1'b0, rd);
    expect_value("readback x", 32'hc0de_1234, rd);
    bus_access("readback w", 1'b1, `REG_W_ADDR, 32'h0bad_f00d, 1'b0, rd);
    bus_access("readback w", 1'b0, `REG_W_ADDR, '0, 1'b0, rd);
    expect_value("readback w", 32'h0bad_f00d, rd);
    bus_access("readback z", 1'b1, `REG_Z_ADDR, 32'h8000_0f00, 1'b0, rd);
    bus_access("readback z", 1'b0, `REG_Z_ADDR, '0, 1'b0, rd);
    expect_value("readback z", 32'h8000_0f00, rd);
    bus_access("readback len", 1'b1, `REG_LEN, 32'h0000_a5c3, 1'b0, rd);
    bus_access("readback len", 1'b0, `REG_LEN, '0, 1'b0, rd);
    expect_value("readback len", 32'h0000_a5c3, rd);

    start_job("len1", 32'h000, 32'h100, 32'h200, 16'd1);
    finish_job("len1", 32'h000, 32'h100, 32'h200, 16'd1);
    start_job("len7", 32'h000, 32'h100, 32'h200, 16'd7);
    finish_job("len7", 32'h000, 32'h100, 32'h200, 16'd7);
    start_job("len32", 32'h000, 32'h100, 32'h200, 16'd32);
    finish_job("len32", 32'h000, 32'h100, 32'h200, 16'd32);

    // Long job, poked while it runs
    start_job("len64", 32'h040, 32'h140, 32'h201, 16'd64);
    bus_access("busy status", 1'b0, `REG_STATUS, '0, 1'b0, rd);
    expect_value("busy status", data_t'(1) << `STATUS_BUSY_BIT, rd);
    bus_access("busy x write", 1'b1, `REG_X_ADDR, 32'h0000_03ff, 1'b1, rd);
    bus_access("busy x read", 1'b0, `REG_X_ADDR, '0, 1'b0, rd);
    expect_value("busy x read", 32'h040, rd);
    finish_job("len64", 32'h040, 32'h140, 32'h201, 16'd64);

    bus_access("unknown read", 1'b0, 8'h18, '0, 1'b1, rd);
    bus_access("unknown write", 1'b1, 8'h3c, 32'h1, 1'b1, rd);

    start_job("len0", 32'h000, 32'h100, 32'h202, 16'd0);
    finish_job("len0", 32'h000, 32'h100, 32'h202, 16'd0);

    if (depth_err) begin
      $display("Memory model saw more reads in flight than the design may have");
      errors++;
    end
    // Let the checker empty its queue
    @(negedge clk_i);
    #1;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_accel

// File: test/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int unsigned Depth       = 1024,
  parameter int unsigned MaxInFlight = 6
)(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        wen_i,
  input  logic [31:0] add_i,
  input  logic [31:0] data_i,
  output logic        gnt_o,
  output logic        r_valid_o,
  output logic [31:0] r_data_o,
  output logic        depth_err_o
);

  logic [31:0] mem [Depth];

  initial begin
    logic        take;
    logic        is_rd;
    logic        resp_rd;
    logic [31:0] add_s;
    logic [31:0] data_s;
    int unsigned in_flight;
    // Every index bit shows up in the word
    for (int unsigned a = 0; a < Depth; a++) begin
      mem[a] = {a[15:0] ^ 16'h5a5a, ~a[15:0]};
    end
    gnt_o       = 1'b0;
    r_valid_o   = 1'b0;
    r_data_o    = '0;
    depth_err_o = 1'b0;
    resp_rd     = 1'b0;
    in_flight   = 0;
    forever begin
      // Request side is stable mid-cycle
      @(negedge clk_i);
      take   = req_i & gnt_o;
      is_rd  = wen_i;
      add_s  = add_i;
      data_s = data_i;
      @(posedge clk_i);
      #1;
      // Last response got registered by the DUT at this edge
      if (resp_rd) in_flight--;
      resp_rd = take & is_rd;
      if (take && is_rd) begin
        in_flight++;
        r_data_o = mem[add_s % Depth];
      end else if (take) begin
        mem[add_s % Depth] = data_s;
      end
      r_valid_o = take;
      if (in_flight > MaxInFlight) depth_err_o = 1'b1;
      // Roughly 30 percent stalls
      gnt_o = rst_ni & req_i & ($urandom_range(9) >= 3);
    end
  end

endmodule : tb_mem_model

// File: vlog.f
+incdir+include
logic/accel_pkg.sv
logic/tcdm_if.sv
logic/accel_ctrl_regs.sv
logic/accel_streamer.sv
logic/accel_mac.sv
logic/accel_wrap.sv
test/tb_mem_model.sv
test/tb_accel.sv
